// ==== design/ram_macros.svh ====
/* banked ram constants */

`ifndef RAM_MACROS_SVH
`define RAM_MACROS_SVH

// byte address across the whole 16 KiB
`define RAM_ADDR_BITS 14
// address inside one 2 KiB bank
`define BANK_ADDR_BITS 11
// upper address bits pick the bank
`define BANK_SEL_BITS 3
`define BANK_COUNT 8

`define BYTE_BITS 8

// axi4-lite data path
`define AXIL_DATA_BITS 32
// bytes per bus word, and the width of a lane index
`define LANE_COUNT 4
`define LANE_BITS 2

`endif

// ==== design/ram_pkg.sv ====
/* banked ram types */

`include "ram_macros.svh"

package ram_pkg;

	typedef logic [`BYTE_BITS-1:0] byte_t;
	// full byte address and in-bank address
	typedef logic [`RAM_ADDR_BITS-1:0] mem_addr_t;
	typedef logic [`BANK_ADDR_BITS-1:0] bank_addr_t;
	typedef logic [`BANK_SEL_BITS-1:0] bank_sel_t;
	// one-hot, one bit per bank
	typedef logic [`BANK_COUNT-1:0] bank_en_t;
	typedef logic [`AXIL_DATA_BITS-1:0] axil_word_t;
	typedef logic [`LANE_COUNT-1:0] axil_strb_t;
	typedef logic [`LANE_BITS-1:0] lane_t;

	// bus-side control sequencer
	typedef enum logic [2:0] {
		IDLE,
		WRITE_LANES,
		WRITE_RESP,
		READ_LANES,
		READ_WAIT,
		READ_RESP
	} ctrl_state_t;

endpackage

// ==== design/ram_bank.sv ====
/* 2k x 8 memory bank */

`timescale 1ns/100ps

`include "ram_macros.svh"

module ram_bank (
	input logic rclk,
	input logic wr_en,
	input ram_pkg::bank_addr_t wr_addr,
	input ram_pkg::byte_t wr_data,
	input ram_pkg::bank_addr_t rd_addr,
	output ram_pkg::byte_t rd_data
);

	// inferred block ram
	ram_pkg::byte_t mem [0:(1 << `BANK_ADDR_BITS)-1];

	// write port
	always_ff @(posedge rclk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// read data one cycle after the address
	// a read of the address being written returns the old byte
	always_ff @(posedge rclk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== design/bank_write_decode.sv ====
/* bank write decode */

`timescale 1ns/100ps

`include "ram_macros.svh"

module bank_write_decode (
	input logic wr_go,
	input ram_pkg::mem_addr_t wr_base,
	input ram_pkg::lane_t wr_lane,
	input ram_pkg::axil_word_t wr_word,
	input ram_pkg::axil_strb_t wr_strb,
	output ram_pkg::bank_en_t bank_wr_en,
	output ram_pkg::bank_addr_t bank_wr_addr,
	output ram_pkg::byte_t bank_wr_data
);

	// byte address of this lane
	ram_pkg::mem_addr_t lane_addr;
	// bank named by the top address bits
	ram_pkg::bank_sel_t lane_bank;
	// lane is live only when its strobe is set
	logic lane_wr;

	// base is word aligned, so the add just fills the low bits
	assign lane_addr = wr_base + ram_pkg::mem_addr_t'(wr_lane);
	assign lane_bank = lane_addr[`RAM_ADDR_BITS-1 -: `BANK_SEL_BITS];
	assign lane_wr = wr_go && wr_strb[wr_lane];

	// all banks share address and data
	assign bank_wr_addr = lane_addr[`BANK_ADDR_BITS-1:0];

	// steer the lane's byte down to the bank data bus
	// lane 0 is bits 7:0
	assign bank_wr_data = wr_word[wr_lane * `BYTE_BITS +: `BYTE_BITS];

	// one-hot enable demux
	always_comb begin
		bank_wr_en = '0;
		if (lane_wr) begin
			bank_wr_en[lane_bank] = 1'b1;
		end
	end

endmodule

// ==== design/bank_read_path.sv ====
/* bank read mux and word packer */

`timescale 1ns/100ps

`include "ram_macros.svh"

module bank_read_path (
	input logic rclk,
	input logic reset,
	input logic rd_go,
	input ram_pkg::mem_addr_t rd_addr,
	output ram_pkg::bank_addr_t bank_rd_addr,
	input ram_pkg::byte_t bank_rd_data [`BANK_COUNT],
	output ram_pkg::axil_word_t rd_word,
	output logic rd_word_done
);

	// stage 1 runs alongside the bank read register
	ram_pkg::bank_sel_t sel_q;
	logic sel_vld;
	// stage 2 holds the output byte
	ram_pkg::byte_t byte_q;
	logic byte_vld;
	// bytes packed so far in this word
	ram_pkg::lane_t lane_cnt;

	// every bank sees the same in-bank address
	assign bank_rd_addr = rd_addr[`BANK_ADDR_BITS-1:0];

	always_ff @(posedge rclk) begin
		if (reset) begin
			sel_vld <= 1'b0;
			byte_vld <= 1'b0;
			lane_cnt <= '0;
			rd_word_done <= 1'b0;
		end else begin
			sel_vld <= rd_go;
			byte_vld <= sel_vld;
			rd_word_done <= 1'b0;
			if (byte_vld) begin
				lane_cnt <= lane_cnt + 1'b1;
				// fourth byte completes the word
				rd_word_done <= (lane_cnt == ram_pkg::lane_t'(`LANE_COUNT-1));
			end
		end
	end

	// payload registers
	always_ff @(posedge rclk) begin
		sel_q <= rd_addr[`RAM_ADDR_BITS-1 -: `BANK_SEL_BITS];
		// byte out two cycles after rd_go
		byte_q <= bank_rd_data[sel_q];
		// lane 0 arrives first and ends up in the low byte
		if (byte_vld) begin
			rd_word <= {byte_q, rd_word[`AXIL_DATA_BITS-1:`BYTE_BITS]};
		end
	end

endmodule

// ==== design/axil_mem_ctrl.sv ====
/* axi4-lite memory control */

`timescale 1ns/100ps

`include "ram_macros.svh"

module axil_mem_ctrl (
	input logic rclk,
	input logic reset,

	// write address
	input logic awvalid,
	output logic awready,
	input ram_pkg::mem_addr_t awaddr,
	// write data
	input logic wvalid,
	output logic wready,
	input ram_pkg::axil_word_t wdata,
	input ram_pkg::axil_strb_t wstrb,
	// write response
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	// read address
	input logic arvalid,
	output logic arready,
	input ram_pkg::mem_addr_t araddr,
	// read data
	output logic rvalid,
	input logic rready,
	output ram_pkg::axil_word_t rdata,
	output logic [1:0] rresp,

	// lane writes towards the decode
	output logic wr_go,
	output ram_pkg::mem_addr_t wr_base,
	output ram_pkg::lane_t wr_lane,
	output ram_pkg::axil_word_t wr_word,
	output ram_pkg::axil_strb_t wr_strb,

	// lane reads and the packed word back
	output logic rd_go,
	output ram_pkg::mem_addr_t rd_addr,
	input ram_pkg::axil_word_t rd_word,
	input logic rd_word_done
);

	ram_pkg::ctrl_state_t state;
	ram_pkg::ctrl_state_t state_nxt;
	// which lane of the word is being accessed
	ram_pkg::lane_t lane_cnt;
	logic last_lane;
	// both write channels present together
	logic wr_req;
	// latched request
	ram_pkg::mem_addr_t addr_q;
	ram_pkg::axil_word_t word_q;
	ram_pkg::axil_strb_t strb_q;
	// read data held for the r channel
	ram_pkg::axil_word_t rdata_q;

	assign wr_req = awvalid && wvalid;
	assign last_lane = (lane_cnt == ram_pkg::lane_t'(`LANE_COUNT-1));

	// aw and w are taken in the same cycle
	// a write wins over a read when both are waiting
	assign awready = (state == ram_pkg::IDLE) && wr_req;
	assign wready = (state == ram_pkg::IDLE) && wr_req;
	assign arready = (state == ram_pkg::IDLE) && arvalid && !wr_req;

	// responses are always OKAY
	assign bvalid = (state == ram_pkg::WRITE_RESP);
	assign bresp = 2'b00;
	assign rvalid = (state == ram_pkg::READ_RESP);
	assign rdata = rdata_q;
	assign rresp = 2'b00;

	// lane sequencing
	assign wr_go = (state == ram_pkg::WRITE_LANES);
	assign wr_lane = lane_cnt;
	// low address bits are ignored
	assign wr_base = {addr_q[`RAM_ADDR_BITS-1:`LANE_BITS], {`LANE_BITS{1'b0}}};
	assign wr_word = word_q;
	assign wr_strb = strb_q;
	assign rd_go = (state == ram_pkg::READ_LANES);
	assign rd_addr = {addr_q[`RAM_ADDR_BITS-1:`LANE_BITS], lane_cnt};

	always_comb begin
		state_nxt = state;
		case (state)
			ram_pkg::IDLE: begin
				if (wr_req) begin
					state_nxt = ram_pkg::WRITE_LANES;
				end else if (arvalid) begin
					state_nxt = ram_pkg::READ_LANES;
				end
			end
			ram_pkg::WRITE_LANES: begin
				if (last_lane) begin
					state_nxt = ram_pkg::WRITE_RESP;
				end
			end
			ram_pkg::WRITE_RESP: begin
				if (bready) begin
					state_nxt = ram_pkg::IDLE;
				end
			end
			ram_pkg::READ_LANES: begin
				if (last_lane) begin
					state_nxt = ram_pkg::READ_WAIT;
				end
			end
			// bytes still in the read pipe
			ram_pkg::READ_WAIT: begin
				if (rd_word_done) begin
					state_nxt = ram_pkg::READ_RESP;
				end
			end
			ram_pkg::READ_RESP: begin
				if (rready) begin
					state_nxt = ram_pkg::IDLE;
				end
			end
			default: state_nxt = ram_pkg::IDLE;
		endcase
	end

	always_ff @(posedge rclk) begin
		if (reset) begin
			state <= ram_pkg::IDLE;
			lane_cnt <= '0;
		end else begin
			state <= state_nxt;
			// counts 0..3 then wraps back to 0 for the next access
			if (wr_go || rd_go) begin
				lane_cnt <= lane_cnt + 1'b1;
			end
		end
	end

	// request and response payload
	always_ff @(posedge rclk) begin
		if (awready) begin
			addr_q <= awaddr;
			word_q <= wdata;
			strb_q <= wstrb;
		end else if (arready) begin
			addr_q <= araddr;
		end
		if (state == ram_pkg::READ_WAIT && rd_word_done) begin
			rdata_q <= rd_word;
		end
	end

endmodule

// ==== design/banked_ram_top.sv ====
/* banked ram, axi4-lite */

`timescale 1ns/100ps

`include "ram_macros.svh"

module banked_ram_top (
	input logic rclk,
	input logic reset,

	input logic awvalid,
	output logic awready,
	input ram_pkg::mem_addr_t awaddr,

	input logic wvalid,
	output logic wready,
	input ram_pkg::axil_word_t wdata,
	input ram_pkg::axil_strb_t wstrb,

	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,

	input logic arvalid,
	output logic arready,
	input ram_pkg::mem_addr_t araddr,

	output logic rvalid,
	input logic rready,
	output ram_pkg::axil_word_t rdata,
	output logic [1:0] rresp
);

	// control to write decode
	logic wr_go;
	ram_pkg::mem_addr_t wr_base;
	ram_pkg::lane_t wr_lane;
	ram_pkg::axil_word_t wr_word;
	ram_pkg::axil_strb_t wr_strb;
	// control to read path
	logic rd_go;
	ram_pkg::mem_addr_t rd_addr;
	ram_pkg::axil_word_t rd_word;
	logic rd_word_done;
	// shared bank buses
	ram_pkg::bank_en_t bank_wr_en;
	ram_pkg::bank_addr_t bank_wr_addr;
	ram_pkg::byte_t bank_wr_data;
	ram_pkg::bank_addr_t bank_rd_addr;
	ram_pkg::byte_t bank_rd_data [`BANK_COUNT];

	axil_mem_ctrl u_ctrl (
		.rclk(rclk), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.wr_go(wr_go), .wr_base(wr_base), .wr_lane(wr_lane),
		.wr_word(wr_word), .wr_strb(wr_strb),
		.rd_go(rd_go), .rd_addr(rd_addr),
		.rd_word(rd_word), .rd_word_done(rd_word_done)
	);

	bank_write_decode u_wr_decode (
		.wr_go(wr_go), .wr_base(wr_base), .wr_lane(wr_lane),
		.wr_word(wr_word), .wr_strb(wr_strb),
		.bank_wr_en(bank_wr_en), .bank_wr_addr(bank_wr_addr),
		.bank_wr_data(bank_wr_data)
	);

	// eight 2k banks make up the 16k space
	for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_bank
		ram_bank u_bank (
			.rclk(rclk),
			.wr_en(bank_wr_en[g]), .wr_addr(bank_wr_addr), .wr_data(bank_wr_data),
			.rd_addr(bank_rd_addr), .rd_data(bank_rd_data[g])
		);
	end

	bank_read_path u_rd_path (
		.rclk(rclk), .reset(reset),
		.rd_go(rd_go), .rd_addr(rd_addr),
		.bank_rd_addr(bank_rd_addr), .bank_rd_data(bank_rd_data),
		.rd_word(rd_word), .rd_word_done(rd_word_done)
	);

endmodule

// ==== bench/banked_ram_tb.sv ====
/* banked ram testbench */

`timescale 1ns/100ps

`include "ram_macros.svh"

module banked_ram_tb;

	// cycles any single wait may take
	localparam int WAIT_LIMIT = 64;
	localparam int MEM_BYTES = 1 << `RAM_ADDR_BITS;

	logic rclk;
	logic reset;
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;
	ram_pkg::mem_addr_t awaddr;
	ram_pkg::mem_addr_t araddr;
	ram_pkg::axil_word_t wdata;
	ram_pkg::axil_word_t rdata;
	ram_pkg::axil_strb_t wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;

	// byte model of the whole memory with a flag for each written byte
	ram_pkg::byte_t model_mem [MEM_BYTES];
	bit model_known [MEM_BYTES];
	int checks;
	int errors;
	int n_tests;
	bit hung;

	banked_ram_top DUT (.*);

	// 20 ns period
	always #10 rclk = ~rclk;

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic flag_timeout(input string what);
		if (!hung) begin
			hung = 1'b1;
			errors++;
			$display("timeout while waiting for %s", what);
		end
	endtask

	task automatic check_idle_outputs();
		check_value("awready", 32'(awready), 0);
		check_value("wready", 32'(wready), 0);
		check_value("arready", 32'(arready), 0);
		check_value("bvalid", 32'(bvalid), 0);
		check_value("rvalid", 32'(rvalid), 0);
	endtask

	// only lanes with a strobe change and address bits 1:0 are ignored
	task automatic model_write(input ram_pkg::mem_addr_t addr, input ram_pkg::axil_word_t data,
			input ram_pkg::axil_strb_t strb);
		int base;
		base = int'(addr) & ~(`LANE_COUNT - 1);
		for (int i = 0; i < `LANE_COUNT; i++) begin
			if (strb[i]) begin
				model_mem[base + i] = data[i*8 +: 8];
				model_known[base + i] = 1'b1;
			end
		end
	endtask

	// little endian word with bytes never written masked out
	task automatic check_read(input ram_pkg::mem_addr_t addr, input ram_pkg::axil_word_t got);
		int base;
		ram_pkg::axil_word_t exp;
		ram_pkg::axil_word_t mask;
		base = int'(addr) & ~(`LANE_COUNT - 1);
		exp = '0;
		mask = '0;
		for (int i = 0; i < `LANE_COUNT; i++) begin
			if (model_known[base + i]) begin
				exp[i*8 +: 8] = model_mem[base + i];
				mask[i*8 +: 8] = 8'hff;
			end
		end
		check_value("rdata", got & mask, exp);
	endtask

	// wait for bvalid or rvalid and stall the ready for some cycles before taking it
	task automatic take_response(input bit is_read, input int stall,
			output ram_pkg::axil_word_t data);
		int cnt;
		ram_pkg::axil_word_t held;
		data = '0;
		bready = !is_read && (stall == 0);
		rready = is_read && (stall == 0);
		#1;
		cnt = 0;
		while (!(is_read ? rvalid : bvalid) && !hung) begin
			@(negedge rclk);
			#1;
			cnt++;
			if (cnt > WAIT_LIMIT) flag_timeout(is_read ? "rvalid" : "bvalid");
		end
		held = rdata;
		for (int i = 0; i < stall && !hung; i++) begin
			// the response holds and no new request is taken
			check_value(is_read ? "rvalid" : "bvalid", 32'(is_read ? rvalid : bvalid), 1);
			if (is_read) check_value("rdata", rdata, held);
			check_value("awready", 32'(awready), 0);
			check_value("arready", 32'(arready), 0);
			@(negedge rclk);
			if (i == stall - 1) begin
				bready = !is_read;
				rready = is_read;
			end
			#1;
		end
		if (!hung) begin
			check_value(is_read ? "rvalid" : "bvalid", 32'(is_read ? rvalid : bvalid), 1);
			check_value(is_read ? "rresp" : "bresp", 32'(is_read ? rresp : bresp), 0);
			if (is_read) check_value("rdata", rdata, held);
			data = rdata;
			// handshake on the rising edge in between
			@(negedge rclk);
		end
		bready = 1'b0;
		rready = 1'b0;
	endtask

	// wvalid may lag awvalid by w_delay cycles
	// with_read queues a read of the same address behind the write
	// already_up means the write went out during an earlier read response
	task automatic axil_write(input ram_pkg::mem_addr_t addr, input ram_pkg::axil_word_t data,
			input ram_pkg::axil_strb_t strb, input int w_delay, input int b_stall,
			input bit with_read, input bit already_up);
		int cnt;
		bit accepted;
		ram_pkg::axil_word_t unused;
		if (!hung) begin
			if (!already_up) begin
				@(negedge rclk);
				awvalid = 1'b1;
				awaddr = addr;
				wdata = data;
				wstrb = strb;
				wvalid = (w_delay == 0);
			end
			if (with_read) begin
				arvalid = 1'b1;
				araddr = addr;
			end
			cnt = 0;
			accepted = 1'b0;
			while (!accepted && !hung) begin
				#1;
				accepted = awready && wready;
				// aw and w are taken in the same cycle
				check_value("wready", 32'(wready), 32'(awready));
				// a pending read waits behind the write
				if (with_read) check_value("arready", 32'(arready), 0);
				@(negedge rclk);
				cnt++;
				if (!accepted && cnt >= w_delay) wvalid = 1'b1;
				if (!accepted && cnt > WAIT_LIMIT) flag_timeout("awready and wready");
			end
			awvalid = 1'b0;
			wvalid = 1'b0;
			model_write(addr, data, strb);
			take_response(1'b0, b_stall, unused);
		end
	endtask

	// already_up means arvalid went out behind a write
	// write_next raises the write already on awaddr, wdata and wstrb during the r response
	task automatic axil_read(input ram_pkg::mem_addr_t addr, input int r_stall,
			input bit already_up, input bit write_next);
		int cnt;
		bit accepted;
		ram_pkg::axil_word_t data;
		if (!hung) begin
			if (!already_up) begin
				@(negedge rclk);
				arvalid = 1'b1;
				araddr = addr;
			end
			cnt = 0;
			accepted = 1'b0;
			while (!accepted && !hung) begin
				#1;
				accepted = arready;
				@(negedge rclk);
				cnt++;
				if (!accepted && cnt > WAIT_LIMIT) flag_timeout("arready");
			end
			arvalid = 1'b0;
			if (write_next) begin
				awvalid = 1'b1;
				wvalid = 1'b1;
			end
			take_response(1'b1, r_stall, data);
			if (!hung) check_read(addr, data);
		end
	endtask

	task automatic end_test(input string name, input int mark);
		n_tests++;
		if (errors == mark) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - mark);
	endtask

	initial begin
		ram_pkg::mem_addr_t addr;
		ram_pkg::axil_word_t word;
		ram_pkg::mem_addr_t used [$];
		int mark;
		void'($urandom(32'hab89_1d4f));
		rclk = 1'b0;
		reset = 1'b1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		checks = 0;
		errors = 0;
		n_tests = 0;
		hung = 1'b0;

		// five reset cycles and one more with reset low
		mark = errors;
		for (int i = 0; i <= 5; i++) begin
			@(negedge rclk);
			check_idle_outputs();
			if (i == 4) reset = 1'b0;
		end
		end_test("reset", mark);

		mark = errors;
		addr = ram_pkg::mem_addr_t'($urandom);
		axil_write(addr, $urandom, 4'hf, 0, 0, 1'b0, 1'b0);
		axil_read(addr, 0, 1'b0, 1'b0);
		end_test("full word", mark);

		// bytes 1 and 3 keep the first word
		mark = errors;
		addr = ram_pkg::mem_addr_t'($urandom);
		axil_write(addr, $urandom, 4'hf, 0, 0, 1'b0, 1'b0);
		axil_write(addr, $urandom, 4'b0101, 0, 0, 1'b0, 1'b0);
		axil_read(addr, 0, 1'b0, 1'b0);
		end_test("partial strobes", mark);

		// same in-bank address in every bank with the index in bits 13:11
		mark = errors;
		addr = ram_pkg::mem_addr_t'($urandom);
		word = $urandom;
		for (int b = 0; b < `BANK_COUNT; b++) begin
			axil_write({ram_pkg::bank_sel_t'(b), addr[`BANK_ADDR_BITS-1:0]},
				word + b * 32'h0101_0101, 4'hf, 0, 0, 1'b0, 1'b0);
		end
		for (int b = 0; b < `BANK_COUNT; b++) begin
			axil_read({ram_pkg::bank_sel_t'(b), addr[`BANK_ADDR_BITS-1:0]}, 0, 1'b0, 1'b0);
		end
		end_test("bank independence", mark);

		// a read waits behind the stalled write response
		// then a new write of the same word waits behind the stalled read response
		mark = errors;
		for (int i = 0; i < 4; i++) begin
			addr = ram_pkg::mem_addr_t'($urandom);
			word = $urandom;
			axil_write(addr, word, 4'hf, 0, 1 + $urandom % 8, 1'b1, 1'b0);
			awaddr = addr;
			wdata = ~word;
			wstrb = 4'hf;
			axil_read(addr, 1 + $urandom % 8, 1'b1, 1'b1);
			axil_write(addr, ~word, 4'hf, 0, 0, 1'b0, 1'b1);
		end
		end_test("back-pressure", mark);

		// half the reads revisit a written word and half land anywhere
		mark = errors;
		for (int i = 0; i < 200; i++) begin
			addr = ram_pkg::mem_addr_t'($urandom);
			used.push_back(addr);
			axil_write(addr, $urandom, ram_pkg::axil_strb_t'($urandom),
				($urandom % 4 == 0) ? 1 + $urandom % 3 : 0, $urandom % 3, 1'b0, 1'b0);
			if ($urandom % 2 != 0) addr = used[$urandom % used.size()];
			else addr = ram_pkg::mem_addr_t'($urandom);
			axil_read(addr, $urandom % 3, 1'b0, 1'b0);
		end
		end_test("random traffic", mark);

		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0 && !hung) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+design
design/ram_pkg.sv
design/ram_bank.sv
design/bank_write_decode.sv
design/bank_read_path.sv
design/axil_mem_ctrl.sv
design/banked_ram_top.sv
bench/banked_ram_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the banked ram testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f all.f --top-module banked_ram_tb -Mdir obj_dir -o banked_ram_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/banked_ram_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# the testbench prints the pass line only when every check held
if echo "$sim_out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
